// File: include/branch_cfg.svh
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// ######################################################################
// widths
// ######################################################################

// pc and branch target width, offsets are truncated to this
`define BR_ADDR_W 16

// register operand width
`define BR_DATA_W 16

// branch id width, one buffer entry per id
`define BR_ID_W 2

// ######################################################################
// opcodes, top six bits of the instruction word
// ######################################################################

`define BR_OP_JMP 6'h02
`define BR_OP_BEQ 6'h04
`define BR_OP_BNE 6'h05
`define BR_OP_BLT 6'h06  // signed compare

`endif

// File: verilog/branch_pkg.sv
package branch_pkg;

    // ######################################################################
    // branch classification
    // ######################################################################

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JUMP
    } branch_kind_e;

    // lt compares the operands as signed values
    typedef enum logic [1:0] {
        COND_EQ,
        COND_NE,
        COND_LT
    } branch_cond_e;

    // ######################################################################
    // instruction word
    // ######################################################################

    // conditional branch format, byte offset relative to pc
    typedef struct packed {
        logic [5:0]         opcode;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic signed [15:0] offset;
    } b_fmt_t;

    // direct jump format with the wider offset
    typedef struct packed {
        logic [5:0]         opcode;
        logic signed [25:0] offset;
    } j_fmt_t;

    // opcode sits in the same bits in both formats
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_word_u;

endpackage

// File: verilog/branch_ifs.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

// decode stage register contents, handed to execute
interface branch_op_if;
    import branch_pkg::*;

    logic                  valid;
    logic [`BR_ID_W-1:0]   id;
    branch_kind_e          kind;
    branch_cond_e          cond;
    logic [`BR_ADDR_W-1:0] pc;
    logic                  pred_taken;
    logic [`BR_ADDR_W-1:0] pred_target;
    logic [`BR_DATA_W-1:0] rs1_data;
    logic [`BR_DATA_W-1:0] rs2_data;

    modport decode (output valid, id, kind, cond, pc, pred_taken, pred_target,
                    rs1_data, rs2_data);
    modport execute (input valid, id, kind, cond, pc, pred_taken, pred_target,
                     rs1_data, rs2_data);
endinterface

// execute stage register contents, handed to result
interface branch_res_if;
    logic                  valid;
    logic [`BR_ID_W-1:0]   id;
    logic [`BR_ADDR_W-1:0] pc;
    logic                  taken;
    logic [`BR_ADDR_W-1:0] actual_target;
    logic                  pred_taken;
    logic [`BR_ADDR_W-1:0] pred_target;

    modport execute (output valid, id, pc, taken, actual_target, pred_taken, pred_target);
    modport result (input valid, id, pc, taken, actual_target, pred_taken, pred_target);
endinterface

// File: verilog/branch_target_buffer.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_target_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  v_i,
    input  logic [`BR_ID_W-1:0]   pred_id_i,
    input  logic [`BR_ADDR_W-1:0] pc_i,
    input  logic [`BR_ADDR_W-1:0] branch_addr_i,
    input  logic [`BR_ID_W-1:0]   branch_id_i,
    output logic                  v_o,
    output logic [`BR_ADDR_W-1:0] pc_o,
    output logic [`BR_ADDR_W-1:0] branch_addr_o,
    input  logic                  delete_i,
    input  logic [`BR_ID_W-1:0]   delete_id_i
);

    localparam int ENTRIES = 1 << `BR_ID_W;

    logic [`BR_ADDR_W-1:0] pc_mem     [ENTRIES];
    logic [`BR_ADDR_W-1:0] target_mem [ENTRIES];
    logic [ENTRIES-1:0]    valid_r;

    // ######################################################################
    // lookup by branch id
    // ######################################################################

    assign v_o           = valid_r[branch_id_i];
    assign pc_o          = pc_mem[branch_id_i];
    assign branch_addr_o = target_mem[branch_id_i];

    // ######################################################################
    // allocate and release
    // ######################################################################

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_r <= '0;
        end else begin
            if (delete_i) begin
                valid_r[delete_id_i] <= 1'b0;
            end
            // a new branch taking the id being released keeps it valid
            if (v_i) begin
                valid_r[pred_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (v_i) begin
            pc_mem[pred_id_i]     <= pc_i;
            target_mem[pred_id_i] <= branch_addr_i;
        end
    end

endmodule

// File: verilog/branch_decode.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_v_i,
    input  branch_pkg::instr_word_u instr_i,
    input  logic [`BR_ADDR_W-1:0]   pc_i,
    input  logic [`BR_DATA_W-1:0]   rs1_data_i,
    input  logic [`BR_DATA_W-1:0]   rs2_data_i,
    input  logic                    flush_i,
    branch_op_if.decode             op,
    output logic                    btb_v_o,
    output logic [`BR_ID_W-1:0]     btb_id_o,
    output logic [`BR_ADDR_W-1:0]   btb_pc_o,
    output logic [`BR_ADDR_W-1:0]   btb_target_o
);
    import branch_pkg::*;

    branch_kind_e          kind;
    branch_cond_e          cond;
    logic [`BR_ADDR_W-1:0] target;
    logic                  pred_taken;
    logic [`BR_ID_W-1:0]   id_r;

    // ######################################################################
    // recognition and static prediction
    // ######################################################################

    always_comb begin
        kind = BR_NONE;
        cond = COND_EQ;
        case (instr_i.b_fmt.opcode)
            `BR_OP_BEQ: kind = BR_COND;
            `BR_OP_BNE: begin
                kind = BR_COND;
                cond = COND_NE;
            end
            `BR_OP_BLT: begin
                kind = BR_COND;
                cond = COND_LT;
            end
            `BR_OP_JMP: kind = BR_JUMP;
            default: kind = BR_NONE;  // anything else is not ours
        endcase
    end

    // offsets wrap into the pc width, where both formats hold the same low bits
    assign target = pc_i + instr_i.b_fmt.offset[`BR_ADDR_W-1:0];

    // backward conditional branches are usually loop closers
    assign pred_taken = (kind == BR_JUMP) || (kind == BR_COND && instr_i.b_fmt.offset[15]);

    // an issue arriving during a flush is younger than the mispredict
    assign btb_v_o      = issue_v_i && (kind != BR_NONE) && !flush_i;
    assign btb_id_o     = id_r;
    assign btb_pc_o     = pc_i;
    assign btb_target_o = target;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            id_r <= '0;
        end else if (btb_v_o) begin
            id_r <= id_r + 1'b1;  // wraps over the four entries
        end
    end

    // ######################################################################
    // decode stage register
    // ######################################################################

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= btb_v_o;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_v_o) begin
            op.id          <= id_r;
            op.kind        <= kind;
            op.cond        <= cond;
            op.pc          <= pc_i;
            op.pred_taken  <= pred_taken;
            op.pred_target <= target;
            op.rs1_data    <= rs1_data_i;
            op.rs2_data    <= rs2_data_i;
        end
    end

endmodule

// File: verilog/branch_execute.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush_i,
    branch_op_if.execute          op,
    output logic [`BR_ID_W-1:0]   btb_id_o,
    input  logic                  btb_v_i,
    input  logic [`BR_ADDR_W-1:0] btb_pc_i,
    input  logic [`BR_ADDR_W-1:0] btb_target_i,
    branch_res_if.execute         res
);
    import branch_pkg::*;

    localparam logic [`BR_ADDR_W-1:0] PC_STEP = 4;

    logic                  cond_true;
    logic                  taken;
    logic                  hit;
    logic [`BR_ADDR_W-1:0] actual_target;

    // ######################################################################
    // condition and next pc
    // ######################################################################

    always_comb begin
        case (op.cond)
            COND_NE: cond_true = op.rs1_data != op.rs2_data;
            COND_LT: cond_true = $signed(op.rs1_data) < $signed(op.rs2_data);
            default: cond_true = op.rs1_data == op.rs2_data;
        endcase
    end

    assign taken = (op.kind == BR_JUMP) || (op.kind == BR_COND && cond_true);

    // the entry is read back by id
    assign btb_id_o = op.id;

    // fall through is the next sequential word
    assign actual_target = taken ? btb_target_i : btb_pc_i + PC_STEP;

    // entry must still be live and belong to this branch
    assign hit = op.valid && btb_v_i && (btb_pc_i == op.pc);

    // ######################################################################
    // execute stage register
    // ######################################################################

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= hit && !flush_i;  // decode contents are squashed on flush
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            res.id            <= op.id;
            res.pc            <= btb_pc_i;
            res.taken         <= taken;
            res.actual_target <= actual_target;
            res.pred_taken    <= op.pred_taken;
            res.pred_target   <= op.pred_target;
        end
    end

endmodule

// File: verilog/branch_result.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_result (
    input  logic                  clk,
    input  logic                  reset,
    branch_res_if.result          res,
    output logic                  resolve_v_o,
    output logic [`BR_ADDR_W-1:0] resolve_pc_o,
    output logic                  taken_o,
    output logic [`BR_ADDR_W-1:0] redirect_addr_o,
    output logic                  mispredict_o,
    output logic                  flush_o,
    output logic                  delete_o,
    output logic [`BR_ID_W-1:0]   delete_id_o
);

    logic mismatch;
    logic accept;

    // ######################################################################
    // misprediction check
    // ######################################################################

    // direction decides, the target compare only matters when both say taken
    assign mismatch = (res.taken != res.pred_taken) ||
                      (res.taken && (res.actual_target != res.pred_target));

    // the branch in execute is younger than a mispredict now resolving
    assign accept = res.valid && !flush_o;

    // release the entry as the branch moves into result, squashed or not
    assign delete_o    = res.valid;
    assign delete_id_o = res.id;

    // one cycle of flush covers the three younger slots
    assign flush_o = mispredict_o;

    // ######################################################################
    // resolution register
    // ######################################################################

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            resolve_v_o  <= 1'b0;
            mispredict_o <= 1'b0;
            taken_o      <= 1'b0;
        end else begin
            resolve_v_o  <= accept;
            mispredict_o <= accept && mismatch;
            taken_o      <= accept && res.taken;
        end
    end

    // address outputs hold until the next accepted resolution
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            resolve_pc_o    <= '0;
            redirect_addr_o <= '0;
        end else if (accept) begin
            resolve_pc_o    <= res.pc;
            redirect_addr_o <= res.actual_target;  // target or pc plus 4
        end
    end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_v_i,
    input  logic [31:0]           instr_i,
    input  logic [`BR_ADDR_W-1:0] pc_i,
    input  logic [`BR_DATA_W-1:0] rs1_data_i,
    input  logic [`BR_DATA_W-1:0] rs2_data_i,
    output logic                  resolve_v_o,
    output logic [`BR_ADDR_W-1:0] resolve_pc_o,
    output logic                  taken_o,
    output logic [`BR_ADDR_W-1:0] redirect_addr_o,
    output logic                  mispredict_o
);

    logic                  btb_wr_v;
    logic [`BR_ID_W-1:0]   btb_wr_id;
    logic [`BR_ADDR_W-1:0] btb_wr_pc;
    logic [`BR_ADDR_W-1:0] btb_wr_target;
    logic [`BR_ID_W-1:0]   btb_rd_id;
    logic                  btb_rd_v;
    logic [`BR_ADDR_W-1:0] btb_rd_pc;
    logic [`BR_ADDR_W-1:0] btb_rd_target;
    logic                  btb_del;
    logic [`BR_ID_W-1:0]   btb_del_id;
    logic                  flush;

    branch_op_if  op_if ();
    branch_res_if res_if ();

    // ######################################################################
    // pipeline: decode, execute, result around the target buffer
    // ######################################################################

    branch_decode decode_i (
        .clk          (clk),
        .reset        (reset),
        .issue_v_i    (issue_v_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .flush_i      (flush),
        .op           (op_if.decode),
        .btb_v_o      (btb_wr_v),
        .btb_id_o     (btb_wr_id),
        .btb_pc_o     (btb_wr_pc),
        .btb_target_o (btb_wr_target)
    );

    branch_execute execute_i (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush),
        .op           (op_if.execute),
        .btb_id_o     (btb_rd_id),
        .btb_v_i      (btb_rd_v),
        .btb_pc_i     (btb_rd_pc),
        .btb_target_i (btb_rd_target),
        .res          (res_if.execute)
    );

    branch_result result_i (
        .clk             (clk),
        .reset           (reset),
        .res             (res_if.result),
        .resolve_v_o     (resolve_v_o),
        .resolve_pc_o    (resolve_pc_o),
        .taken_o         (taken_o),
        .redirect_addr_o (redirect_addr_o),
        .mispredict_o    (mispredict_o),
        .flush_o         (flush),
        .delete_o        (btb_del),
        .delete_id_o     (btb_del_id)
    );

    branch_target_buffer btb_i (
        .clk           (clk),
        .reset         (reset),
        .v_i           (btb_wr_v),
        .pred_id_i     (btb_wr_id),
        .pc_i          (btb_wr_pc),
        .branch_addr_i (btb_wr_target),
        .branch_id_i   (btb_rd_id),
        .v_o           (btb_rd_v),
        .pc_o          (btb_rd_pc),
        .branch_addr_o (btb_rd_target),
        .delete_i      (btb_del),
        .delete_id_i   (btb_del_id)
    );

endmodule

// File: tests/branch_unit_tb.sv
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_unit_tb;

    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 3;
    localparam int GROUPS       = 7;

    // one line of the vector file with the resolution it should produce
    typedef struct packed {
        int                    grp;
        int                    line_no;
        logic                  issue_v;
        logic [31:0]           instr;
        logic [`BR_ADDR_W-1:0] pc;
        logic [`BR_DATA_W-1:0] rs1;
        logic [`BR_DATA_W-1:0] rs2;
        logic                  exp_v;
        logic                  exp_taken;
        logic                  exp_mis;
        logic [`BR_ADDR_W-1:0] exp_redirect;
    } vector_t;

    logic                  clk        = 1'b0;
    logic                  reset      = 1'b0;
    logic                  issue_v_i  = 1'b0;
    logic [31:0]           instr_i    = '0;
    logic [`BR_ADDR_W-1:0] pc_i       = '0;
    logic [`BR_DATA_W-1:0] rs1_data_i = '0;
    logic [`BR_DATA_W-1:0] rs2_data_i = '0;
    logic                  resolve_v_o;
    logic [`BR_ADDR_W-1:0] resolve_pc_o;
    logic                  taken_o;
    logic [`BR_ADDR_W-1:0] redirect_addr_o;
    logic                  mispredict_o;

    vector_t vectors [$];
    vector_t pending [$];  // issued lines waiting for their resolution slot
    string   group_name [GROUPS];
    int      group_last [GROUPS];
    int      group_errors [GROUPS];
    int      error_count   = 0;
    int      check_count   = 0;
    int      groups_passed = 0;
    int      groups_failed = 0;
    int      cycle_count   = 0;
    int      timeout_limit = 1000;
    logic    load_ok;

    branch_unit dut_i (
        .clk             (clk),
        .reset           (reset),
        .issue_v_i       (issue_v_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .resolve_v_o     (resolve_v_o),
        .resolve_pc_o    (resolve_pc_o),
        .taken_o         (taken_o),
        .redirect_addr_o (redirect_addr_o),
        .mispredict_o    (mispredict_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timed out after %0d cycles with vectors still pending", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ######################################################################
    // helpers
    // ######################################################################

    function automatic logic is_branch_opcode(input logic [5:0] opcode);
        return (opcode == `BR_OP_BEQ) || (opcode == `BR_OP_BNE) ||
               (opcode == `BR_OP_BLT) || (opcode == `BR_OP_JMP);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, input int grp);
        check_count++;
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            error_count++;
            group_errors[grp]++;
        end
    endtask

    task automatic report_group(input int grp);
        if (group_errors[grp] == 0) begin
            $display("%-32s done, no mismatches", group_name[grp]);
            groups_passed++;
        end else begin
            $display("%-32s done, %0d mismatches", group_name[grp], group_errors[grp]);
            groups_failed++;
        end
    endtask

    task automatic load_vectors();
        int                    fd;
        int                    count;
        int                    line_no;
        int                    bad_lines;
        int                    grp;
        int                    v;
        int                    ev;
        int                    et;
        int                    em;
        logic [31:0]           instr;
        logic [`BR_ADDR_W-1:0] pc;
        logic [`BR_DATA_W-1:0] rs1;
        logic [`BR_DATA_W-1:0] rs2;
        logic [`BR_ADDR_W-1:0] redirect;
        string                 text;
        vector_t               vec;
        load_ok   = 1'b0;
        line_no   = 0;
        bad_lines = 0;
        fd = $fopen("tests/branch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/branch_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                text  = "";
                count = $fgets(text, fd);
                line_no++;
                if (text.len() > 1 && text.getc(0) != "#") begin
                    count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                                    grp, v, instr, pc, rs1, rs2, ev, et, em, redirect);
                    if (count == 10 && grp > 0 && grp < GROUPS) begin
                        vec = '{grp, line_no, v[0], instr, pc, rs1, rs2,
                                ev[0], et[0], em[0], redirect};
                        vectors.push_back(vec);
                        group_last[grp] = line_no;
                    end else begin
                        $display("line %0d of the vector file could not be read", line_no);
                        bad_lines++;
                    end
                end
            end
            $fclose(fd);
            load_ok = (vectors.size() > 0) && (bad_lines == 0);
        end
    endtask

    // ######################################################################
    // stimulus and checking
    // ######################################################################

    task automatic apply_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        compare_value("reset resolve_v", 0, 32'(resolve_v_o), 0);
        compare_value("reset taken", 0, 32'(taken_o), 0);
        compare_value("reset mispredict", 0, 32'(mispredict_o), 0);
        compare_value("reset resolve_pc", 0, 32'(resolve_pc_o), 0);
        compare_value("reset redirect", 0, 32'(redirect_addr_o), 0);
        report_group(0);
    endtask

    task automatic drive_line(input vector_t vec);
        logic [31:0]           rnd;
        logic [`BR_DATA_W-1:0] rs1;
        logic [`BR_DATA_W-1:0] rs2;
        rs1 = vec.rs1;
        rs2 = vec.rs2;
        if (!is_branch_opcode(vec.instr[31:26])) begin  // filler operands
            rnd = $urandom();
            rs1 = rnd[`BR_DATA_W-1:0];
            rnd = $urandom();
            rs2 = rnd[`BR_DATA_W-1:0];
        end
        issue_v_i  <= vec.issue_v;
        instr_i    <= vec.instr;
        pc_i       <= vec.pc;
        rs1_data_i <= rs1;
        rs2_data_i <= rs2;
    endtask

    task automatic drive_idle();
        issue_v_i  <= 1'b0;
        instr_i    <= '0;
        pc_i       <= '0;
        rs1_data_i <= '0;
        rs2_data_i <= '0;
    endtask

    task automatic verify_line(input vector_t want);
        string tag;
        int    g;
        g   = want.grp;
        tag = $sformatf("%s line %0d", group_name[g], want.line_no);
        compare_value({tag, " resolve_v"}, 32'(want.exp_v), 32'(resolve_v_o), g);
        compare_value({tag, " taken"}, 32'(want.exp_taken), 32'(taken_o), g);
        compare_value({tag, " mispredict"}, 32'(want.exp_mis), 32'(mispredict_o), g);
        if (want.exp_v) begin
            compare_value({tag, " redirect"}, 32'(want.exp_redirect), 32'(redirect_addr_o), g);
            compare_value({tag, " resolve_pc"}, 32'(want.pc), 32'(resolve_pc_o), g);
        end
        if (want.line_no == group_last[g]) begin
            report_group(g);
        end
    endtask

    task automatic run_vectors();
        vector_t want;
        int      i;
        for (i = 0; i < vectors.size() + LATENCY; i++) begin
            @(posedge clk);
            if (i < vectors.size()) begin
                drive_line(vectors[i]);
                pending.push_back(vectors[i]);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (i >= LATENCY) begin  // line i-3 resolves in this cycle
                want = pending.pop_front();
                verify_line(want);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h415b9fa0));
        group_name[0] = "reset state";
        group_name[1] = "predicted conditional branches";
        group_name[2] = "direct jumps";
        group_name[3] = "forward blt mispredict";
        group_name[4] = "backward not taken mispredict";
        group_name[5] = "branch id wrap";
        group_name[6] = "non-branch and idle";
        load_vectors();
        timeout_limit = vectors.size() + RESET_CYCLES + 20;
        if (load_ok) begin
            apply_reset();
            check_reset_state();
            run_vectors();
        end else begin
            $display("no usable vectors were loaded, the run stops without stimulus");
            error_count++;
        end
        $display("groups passed %0d, groups failed %0d, checks %0d, mismatches %0d",
                 groups_passed, groups_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/branch_vectors.txt
# grp issue instr pc rs1 rs2 then expected resolve_v taken mispredict redirect, all hex
# expectations belong to the line itself and appear three cycles after it issues
1 1 1022fff0 0100 0005 0005 1 1 0 00f0
1 1 14640020 0200 0007 0007 1 0 0 0204
1 1 1464fff8 0300 0001 0002 1 1 0 02f8
1 1 10220040 0310 0003 0004 1 0 0 0314
1 1 1822fff0 0400 ffff 0001 1 1 0 03f0
1 1 18220010 0410 0005 8000 1 0 0 0414
2 1 08000100 0500 0000 0000 1 1 0 0600
2 1 0bfffe00 0600 0000 0000 1 1 0 0400
2 1 08000020 fff0 0000 0000 1 1 0 0010
2 1 08010004 1000 0000 0000 1 1 0 1004
3 1 18220080 0700 fffe 0003 1 1 1 0780
3 1 1022fff0 0704 0001 0001 0 0 0 0000
3 1 08000040 0708 0000 0000 0 0 0 0000
3 1 14640010 070c 0001 0002 0 0 0 0000
3 1 1022fff8 0780 0002 0002 1 1 0 0778
4 1 1464ffe0 0800 0009 0009 1 0 1 0804
4 1 08000010 07e0 0000 0000 0 0 0 0000
4 1 20220000 07e4 0000 0000 0 0 0 0000
4 1 1822fff0 07e8 0000 0001 0 0 0 0000
4 1 08000008 0804 0000 0000 1 1 0 080c
5 1 10220010 0900 0001 0002 1 0 0 0904
5 1 1464fff4 0904 0001 0002 1 1 0 08f8
5 1 08000030 0908 0000 0000 1 1 0 0938
5 1 18220020 090c 0007 0003 1 0 0 0910
5 1 1022ffe0 0910 0004 0004 1 1 0 08f0
5 1 1464000c 0914 0006 0006 1 0 0 0918
5 1 0bfffff0 0918 0000 0000 1 1 0 0908
6 1 20220000 0a00 0000 0000 0 0 0 0000
6 0 10220000 0a04 0005 0005 0 0 0 0000
6 1 3c000000 0a08 0000 0000 0 0 0 0000
6 0 00000000 0000 0000 0000 0 0 0 0000
6 1 00000000 0a10 0000 0000 0 0 0 0000

// File: build.f
+incdir+include
verilog/branch_pkg.sv
verilog/branch_ifs.sv
verilog/branch_target_buffer.sv
verilog/branch_decode.sv
verilog/branch_execute.sv
verilog/branch_result.sv
verilog/branch_unit.sv
tests/branch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module branch_unit_tb -f build.f -o sim_branch_unit

output=$(./obj_dir/sim_branch_unit)
echo "$output"

if echo "$output" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1
